//--- build.f
+incdir+include
source/cpu_pkg.sv
source/opcode_decoder.sv
source/alu_core.sv
source/register_file.sv
source/bus_sequencer.sv
source/cpu_top.sv
bench/cpu_sva.sv
bench/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile and run the cpu testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpu_tb -f build.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -qF "*** FAILED ***" sim.log; then
	echo "run_sim: simulation failed"
	exit 1
fi
echo "run_sim: simulation passed"

//--- bench/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb;

	localparam int TEST_COUNT = 48;

	logic           clk = 1'b0;
	logic           reset_routine;
	logic           mem_req;
	logic           mem_we;
	cpu_pkg::addr_t mem_addr;
	cpu_pkg::data_t mem_wdata;
	logic           mem_ack;
	cpu_pkg::data_t mem_rdata;

	cpu_pkg::data_t mem [0:65535];
	logic [31:0]    lcg_state = 32'h23fd_3e36;
	cpu_pkg::addr_t pc_gen;
	int unsigned    n_instr = 0;
	int             ack_wait;
	int             rel_wait;
	logic           gen_done = 1'b0;
	logic           trace_done = 1'b0;
	int             mismatch_errors = 0;
	int             other_errors = 0;

	// expected and observed bus transactions in bus order
	logic           exp_we_q [$];
	cpu_pkg::addr_t exp_addr_q [$];
	cpu_pkg::data_t exp_data_q [$];
	logic           obs_we_q [$];
	cpu_pkg::addr_t obs_addr_q [$];
	cpu_pkg::data_t obs_data_q [$];

	cpu_pkg::opcode_t alu_ops [5] = '{cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM,
		cpu_pkg::OP_AND_IMM, cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_EOR_IMM};
	cpu_pkg::opcode_t br_ops [6] = '{cpu_pkg::OP_BCC, cpu_pkg::OP_BCS, cpu_pkg::OP_BEQ,
		cpu_pkg::OP_BNE, cpu_pkg::OP_BMI, cpu_pkg::OP_BPL};

	cpu_top i_dut (
		.clk (clk), .reset_routine (reset_routine),
		.mem_req (mem_req), .mem_we (mem_we), .mem_addr (mem_addr),
		.mem_wdata (mem_wdata), .mem_ack (mem_ack), .mem_rdata (mem_rdata)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpu_pkg::data_t rand_byte();
		lcg_state = lcg_step(lcg_state);
		return lcg_state[23:16];
	endfunction

	// expected {n, z, c, v, result} of one instruction on a, b and carry
	function automatic logic [11:0] ref_alu(input cpu_pkg::opcode_t op,
		input cpu_pkg::data_t a, input cpu_pkg::data_t b, input logic cin);
		logic [8:0]     s;
		cpu_pkg::data_t bb;
		cpu_pkg::data_t r;
		logic           c;
		logic           v;
		c = cin;
		v = 1'b0;
		case (op)
			cpu_pkg::OP_AND_IMM: r = a & b;
			cpu_pkg::OP_ORA_IMM: r = a | b;
			cpu_pkg::OP_EOR_IMM: r = a ^ b;
			default:
			begin
				// subtract and compare add the inverted operand
				bb = (op == cpu_pkg::OP_ADC_IMM) ? b : ~b;
				s  = {1'b0, a} + {1'b0, bb} +
				     ((op == cpu_pkg::OP_CMP_IMM) ? 9'd1 : {8'd0, cin});
				r  = s[7:0];
				c  = s[8];
				v  = (a[7] == bb[7]) && (r[7] != a[7]);
			end
		endcase
		return {r[7], (r == 8'd0), c, v, r};
	endfunction

	function automatic logic branch_taken(input cpu_pkg::opcode_t br, input logic [11:0] f);
		case (br)
			cpu_pkg::OP_BCC: return !f[9];
			cpu_pkg::OP_BCS: return f[9];
			cpu_pkg::OP_BEQ: return f[10];
			cpu_pkg::OP_BNE: return !f[10];
			cpu_pkg::OP_BMI: return f[11];
			default:         return !f[11];
		endcase
	endfunction

	task automatic check_addr(input string what, input cpu_pkg::addr_t got,
		input cpu_pkg::addr_t exp);
		if (got !== exp)
		begin
			mismatch_errors++;
			$display("MISMATCH %0t: %s is %04h, expected %04h", $time, what, got, exp);
		end
	endtask

	task automatic check_data(input string what, input cpu_pkg::data_t got,
		input cpu_pkg::data_t exp);
		if (got !== exp)
		begin
			mismatch_errors++;
			$display("MISMATCH %0t: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic expect_access(input logic we, input cpu_pkg::addr_t a,
		input cpu_pkg::data_t d);
		exp_we_q.push_back(we);
		exp_addr_q.push_back(a);
		exp_data_q.push_back(d);
	endtask

	task automatic put_byte(input cpu_pkg::data_t b);
		mem[pc_gen] = b;
		expect_access(1'b0, pc_gen, b);
		pc_gen = pc_gen + 16'd1;
	endtask

	task automatic put_op(input cpu_pkg::opcode_t op);
		n_instr++;
		put_byte(op);
	endtask

	task automatic put_addr(input cpu_pkg::addr_t a);
		put_byte(a[7:0]);
		put_byte(a[15:8]);
	endtask

	// LDX or LDY from a preloaded zero-page or absolute byte
	task automatic emit_load(input cpu_pkg::opcode_t zpg_op, input cpu_pkg::opcode_t abs_op,
		output cpu_pkg::data_t v);
		cpu_pkg::data_t pick;
		cpu_pkg::addr_t a;
		pick = rand_byte();
		if (pick[0])
		begin
			a = {`CPU_ZPG_PAGE, 1'b0, pick[7:1]};
			put_op(zpg_op);
			put_byte(a[7:0]);
		end
		else
		begin
			a = {8'h40, rand_byte()};
			put_op(abs_op);
			put_addr(a);
		end
		expect_access(1'b0, a, 8'h00);
		v = mem[a];
	endtask

	task automatic alu_store_test();
		cpu_pkg::data_t   a;
		cpu_pkg::data_t   b;
		cpu_pkg::data_t   zp;
		cpu_pkg::data_t   pick;
		cpu_pkg::opcode_t op;
		logic [11:0]      r;
		pick = rand_byte();
		a    = rand_byte();
		b    = rand_byte();
		zp   = rand_byte() | 8'h80;
		op   = alu_ops[rand_byte() % 8'd5];
		r    = ref_alu(op, a, b, pick[0]);
		put_op(pick[0] ? cpu_pkg::OP_SEC : cpu_pkg::OP_CLC);
		put_op(cpu_pkg::OP_LDA_IMM);
		put_byte(a);
		put_op(op);
		put_byte(b);
		put_op(cpu_pkg::OP_STA_ZPG);
		put_byte(zp);
		expect_access(1'b1, {`CPU_ZPG_PAGE, zp}, r[7:0]);
	endtask

	task automatic reg_path_test();
		cpu_pkg::data_t x_val;
		cpu_pkg::data_t y_val;
		cpu_pkg::addr_t x_dst;
		cpu_pkg::addr_t y_dst;
		x_dst = {8'h80, rand_byte()};
		y_dst = {8'h81, rand_byte()};
		emit_load(cpu_pkg::OP_LDX_ZPG, cpu_pkg::OP_LDX_ABS, x_val);
		put_op(cpu_pkg::OP_INX);
		put_op(cpu_pkg::OP_TXA);
		emit_load(cpu_pkg::OP_LDY_ZPG, cpu_pkg::OP_LDY_ABS, y_val);
		put_op(cpu_pkg::OP_DEY);
		put_op(cpu_pkg::OP_TYA);
		put_op(cpu_pkg::OP_STX_ABS);
		put_addr(x_dst);
		expect_access(1'b1, x_dst, x_val + 8'd1);
		put_op(cpu_pkg::OP_STY_ABS);
		put_addr(y_dst);
		expect_access(1'b1, y_dst, y_val - 8'd1);
	endtask

	task automatic branch_test();
		cpu_pkg::data_t   a;
		cpu_pkg::data_t   b;
		cpu_pkg::data_t   off;
		cpu_pkg::data_t   pick;
		cpu_pkg::opcode_t op;
		cpu_pkg::opcode_t br;
		logic [11:0]      f;
		pick = rand_byte();
		a    = rand_byte();
		b    = pick[1] ? a : rand_byte();
		op   = pick[2] ? cpu_pkg::OP_CMP_IMM : cpu_pkg::OP_ADC_IMM;
		br   = br_ops[rand_byte() % 8'd6];
		f    = ref_alu(op, a, b, pick[0]);
		put_op(pick[0] ? cpu_pkg::OP_SEC : cpu_pkg::OP_CLC);
		put_op(cpu_pkg::OP_LDA_IMM);
		put_byte(a);
		put_op(op);
		put_byte(b);
		put_op(br);
		if (branch_taken(br, f))
		begin
			// forward target crosses a page whenever the low byte wraps
			off = rand_byte() & 8'h7f;
			put_byte(off);
			pc_gen = pc_gen + {8'h00, off};
		end
		else
			put_byte(rand_byte());
	endtask

	task automatic build_program();
		cpu_pkg::data_t kind;
		cpu_pkg::addr_t loop_pc;
		pc_gen = `CPU_RESTART_PC;
		for (int i = 0; i < TEST_COUNT; i++)
		begin
			kind = rand_byte() % 8'd3;
			case (kind)
				8'd0:    alu_store_test();
				8'd1:    reg_path_test();
				default: branch_test();
			endcase
		end
		// closing JMP to itself is fetched three times
		loop_pc = pc_gen;
		put_op(cpu_pkg::OP_JMP_ABS);
		put_addr(loop_pc);
		for (int k = 0; k < 6; k++)
			expect_access(1'b0, loop_pc + cpu_pkg::addr_t'(k % 3), 8'h00);
		n_instr += 2;
	endtask

	task automatic fill_memory();
		logic [15:0] a;
		for (int i = 0; i < 65536; i++)
		begin
			a = i[15:0];
			mem[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
		end
		// load sources for LDX and LDY
		for (int i = 0; i < 128; i++)
			mem[i] = rand_byte();
		for (int i = 0; i < 256; i++)
			mem[16'h4000 + i] = rand_byte();
	endtask

	task automatic compare_next();
		logic           we;
		cpu_pkg::addr_t a;
		cpu_pkg::data_t d;
		we = obs_we_q.pop_front();
		a  = obs_addr_q.pop_front();
		d  = obs_data_q.pop_front();
		if (!trace_done)
		begin
			if (we && !exp_we_q[0])
			begin
				other_errors++;
				$display("unexpected write to %04h, the program reads %04h next",
					a, exp_addr_q[0]);
			end
			else if (!we && exp_we_q[0])
			begin
				other_errors++;
				$display("read of %04h where the program stores to %04h", a, exp_addr_q[0]);
			end
			else if (we)
			begin
				check_addr("store address", a, exp_addr_q[0]);
				check_data("store data", d, exp_data_q[0]);
			end
			else
				check_addr("read address", a, exp_addr_q[0]);
			exp_we_q.delete(0);
			exp_addr_q.delete(0);
			exp_data_q.delete(0);
			if (exp_we_q.size() == 0)
				trace_done = 1'b1;
		end
	endtask

	task automatic finish_run();
		$display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
		if (mismatch_errors == 0 && other_errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	endtask

	// memory raises ack after 0 to 3 cycles and holds it 0 or 1 cycle past the request
	initial
	begin
		mem_ack   = 1'b0;
		mem_rdata = 8'h00;
		ack_wait  = 0;
		rel_wait  = 0;
		forever
		begin
			@(posedge clk);
			#1;
			if (mem_req && !mem_ack)
			begin
				if (ack_wait != 0)
					ack_wait--;
				else
				begin
					if (mem_we)
						mem[mem_addr] = mem_wdata;
					mem_rdata = mem[mem_addr];
					mem_ack   = 1'b1;
					obs_we_q.push_back(mem_we);
					obs_addr_q.push_back(mem_addr);
					obs_data_q.push_back(mem_wdata);
				end
			end
			else if (!mem_req && mem_ack)
			begin
				if (rel_wait != 0)
					rel_wait--;
				else
				begin
					mem_ack  = 1'b0;
					ack_wait = int'(rand_byte() % 8'd4);
					rel_wait = int'(rand_byte() % 8'd2);
				end
			end
		end
	end

	always @(posedge clk)
	begin
		while (obs_we_q.size() > 0)
			compare_next();
	end

	always @(negedge clk)
	begin
		if (reset_routine && mem_req === 1'b1)
		begin
			other_errors++;
			$display("memory request raised while reset is active");
		end
	end

	initial
	begin
		reset_routine = 1'b1;
		fill_memory();
		build_program();
		gen_done = 1'b1;
		repeat (5) @(posedge clk);
		#1;
		reset_routine = 1'b0;
		@(posedge clk);
		#1;
		if (mem_req !== 1'b1)
		begin
			other_errors++;
			$display("no opcode fetch request in the first cycle after reset");
		end
		wait (trace_done);
		repeat (2) @(posedge clk);
		finish_run();
	end

	initial
	begin
		longint unsigned limit_ns;
		wait (gen_done);
		// at most 4 accesses of 6 cycles per instruction
		limit_ns = longint'(n_instr) * 4 * 6 * 20 + 2000;
		#(limit_ns);
		other_errors++;
		$display("timeout: the program did not reach its final loop within %0d ns", limit_ns);
		finish_run();
	end

endmodule

//--- bench/cpu_sva.sv
`timescale 1ns/1ps

module cpu_sva (
	input logic           clk,
	input logic           reset_routine,
	input logic           mem_req,
	input logic           mem_we,
	input cpu_pkg::addr_t mem_addr,
	input cpu_pkg::data_t mem_wdata,
	input logic           mem_ack
);

	// request fields frozen until memory answers
	hold_request: assert property (@(posedge clk) disable iff (reset_routine)
		(mem_req && !mem_ack) |=>
			($stable(mem_addr) && $stable(mem_we) && (!mem_we || $stable(mem_wdata))))
		else $error("bus request changed while waiting for acknowledge");

	// new request only after ack was seen low
	no_rise_under_ack: assert property (@(posedge clk) disable iff (reset_routine)
		$rose(mem_req) |-> !$past(mem_ack))
		else $error("request raised while acknowledge still high");

	quiet_in_reset: assert property (@(posedge clk)
		(reset_routine && $past(reset_routine)) |-> !mem_req)
		else $error("request active during reset");

endmodule

bind bus_sequencer cpu_sva i_sva (
	.clk (clk), .reset_routine (reset_routine), .mem_req (mem_req), .mem_we (mem_we),
	.mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_ack (mem_ack)
);

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top (
	input  logic           clk,
	input  logic           reset_routine,
	output logic           mem_req,
	output logic           mem_we,
	output cpu_pkg::addr_t mem_addr,
	output cpu_pkg::data_t mem_wdata,
	input  logic           mem_ack,
	input  cpu_pkg::data_t mem_rdata
);

	cpu_pkg::data_t        ir;
	cpu_pkg::adr_mode_t    mode;
	cpu_pkg::alu_op_t      alu_op;
	cpu_pkg::reg_sel_t     src_sel;
	cpu_pkg::reg_sel_t     dst_sel;
	logic                  mem_write;
	logic                  upd_nz;
	logic                  upd_c;
	logic                  upd_v;
	logic                  set_c;
	logic                  clr_c;
	cpu_pkg::branch_cond_t branch_cond;
	cpu_pkg::data_t        store_data;
	cpu_pkg::data_t        operand;
	logic                  exec_strobe;
	logic                  flag_n;
	logic                  flag_z;
	logic                  flag_c;

	opcode_decoder i_decoder (
		.ir (ir), .mode (mode), .alu_op (alu_op),
		.src_sel (src_sel), .dst_sel (dst_sel), .mem_write (mem_write),
		.upd_nz (upd_nz), .upd_c (upd_c), .upd_v (upd_v),
		.set_c (set_c), .clr_c (clr_c), .branch_cond (branch_cond)
	);

	bus_sequencer i_sequencer (
		.clk (clk), .reset_routine (reset_routine),
		.mem_req (mem_req), .mem_we (mem_we), .mem_addr (mem_addr),
		.mem_wdata (mem_wdata), .mem_ack (mem_ack), .mem_rdata (mem_rdata),
		.ir (ir), .mode (mode), .mem_write (mem_write), .branch_cond (branch_cond),
		.store_data (store_data), .flag_n (flag_n), .flag_z (flag_z), .flag_c (flag_c),
		.operand (operand), .exec_strobe (exec_strobe)
	);

	register_file i_regs (
		.clk (clk), .reset_routine (reset_routine), .exec_strobe (exec_strobe),
		.operand (operand), .alu_op (alu_op), .src_sel (src_sel), .dst_sel (dst_sel),
		.upd_nz (upd_nz), .upd_c (upd_c), .upd_v (upd_v), .set_c (set_c), .clr_c (clr_c),
		.store_data (store_data), .flag_n (flag_n), .flag_z (flag_z), .flag_c (flag_c)
	);

endmodule

//--- source/bus_sequencer.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module bus_sequencer (
	input  logic                  clk,
	input  logic                  reset_routine,
	output logic                  mem_req,
	output logic                  mem_we,
	output cpu_pkg::addr_t        mem_addr,
	output cpu_pkg::data_t        mem_wdata,
	input  logic                  mem_ack,
	input  cpu_pkg::data_t        mem_rdata,
	output cpu_pkg::data_t        ir,
	input  cpu_pkg::adr_mode_t    mode,
	input  logic                  mem_write,
	input  cpu_pkg::branch_cond_t branch_cond,
	input  cpu_pkg::data_t        store_data,
	input  logic                  flag_n,
	input  logic                  flag_z,
	input  logic                  flag_c,
	output cpu_pkg::data_t        operand,
	output logic                  exec_strobe
);

	cpu_pkg::seq_state_t state;
	cpu_pkg::addr_t      pc;
	cpu_pkg::addr_t      eff_addr;
	cpu_pkg::data_t      adr_lo;

	// set after an ack, cleared once memory drops ack
	logic ack_pend;

	logic           step_mem;
	logic           step_we;
	cpu_pkg::addr_t step_addr;
	logic           can_issue;
	logic           xfer_done;
	logic           taken;
	cpu_pkg::addr_t rel_ext;

	assign can_issue = !mem_req && !(ack_pend && mem_ack);
	assign xfer_done = mem_req && mem_ack;
	assign rel_ext   = {{(`CPU_ADDR_W - `CPU_DATA_W){adr_lo[`CPU_DATA_W-1]}}, adr_lo};

	// does this step need a bus access, and where
	always_comb
	begin
		step_mem  = 1'b0;
		step_we   = 1'b0;
		step_addr = pc;
		case (state)
			cpu_pkg::ST_FETCH:   step_mem = 1'b1;
			cpu_pkg::ST_OPER_LO: step_mem = (mode != cpu_pkg::MODE_IMPL) &&
			                                (mode != cpu_pkg::MODE_INVAL);
			cpu_pkg::ST_OPER_HI: step_mem = 1'b1;
			cpu_pkg::ST_DATA:
			begin
				step_mem  = !mem_write;
				step_addr = eff_addr;
			end
			cpu_pkg::ST_WRITE:
			begin
				step_mem  = 1'b1;
				step_we   = 1'b1;
				step_addr = eff_addr;
			end
			default: step_mem = 1'b0;
		endcase
	end

	always_comb
	begin
		case (branch_cond)
			cpu_pkg::BR_CC: taken = !flag_c;
			cpu_pkg::BR_CS: taken = flag_c;
			cpu_pkg::BR_EQ: taken = flag_z;
			cpu_pkg::BR_NE: taken = !flag_z;
			cpu_pkg::BR_MI: taken = flag_n;
			default:        taken = !flag_n;
		endcase
	end

	always_ff @(posedge clk)
	begin
		exec_strobe <= 1'b0;
		if (reset_routine)
		begin
			state    <= cpu_pkg::ST_FETCH;
			pc       <= `CPU_RESTART_PC;
			mem_req  <= 1'b0;
			mem_we   <= 1'b0;
			ack_pend <= 1'b0;
		end
		else
		begin
			if (ack_pend && !mem_ack)
				ack_pend <= 1'b0;

			// bus outputs change only when a request starts
			if (step_mem && can_issue)
			begin
				mem_req   <= 1'b1;
				mem_we    <= step_we;
				mem_addr  <= step_addr;
				mem_wdata <= store_data;
			end

			if (xfer_done)
			begin
				mem_req  <= 1'b0;
				ack_pend <= 1'b1;
			end

			case (state)
				cpu_pkg::ST_FETCH:
					if (xfer_done)
					begin
						ir    <= mem_rdata;
						pc    <= pc + 1'b1;
						state <= cpu_pkg::ST_OPER_LO;
					end
				cpu_pkg::ST_OPER_LO:
					if (!step_mem)
					begin
						// implied runs here; unknown opcodes fall through as NOP
						exec_strobe <= (mode == cpu_pkg::MODE_IMPL);
						state       <= cpu_pkg::ST_FETCH;
					end
					else if (xfer_done)
					begin
						pc <= pc + 1'b1;
						case (mode)
							cpu_pkg::MODE_IMM:
							begin
								operand     <= mem_rdata;
								exec_strobe <= 1'b1;
								state       <= cpu_pkg::ST_FETCH;
							end
							cpu_pkg::MODE_ZPG:
							begin
								eff_addr <= {`CPU_ZPG_PAGE, mem_rdata};
								state    <= cpu_pkg::ST_DATA;
							end
							cpu_pkg::MODE_REL:
							begin
								adr_lo <= mem_rdata;
								state  <= cpu_pkg::ST_BRANCH;
							end
							default:
							begin
								adr_lo <= mem_rdata;
								state  <= cpu_pkg::ST_OPER_HI;
							end
						endcase
					end
				cpu_pkg::ST_OPER_HI:
					if (xfer_done)
					begin
						if (mode == cpu_pkg::MODE_JMP_ABS)
						begin
							pc    <= {mem_rdata, adr_lo};
							state <= cpu_pkg::ST_FETCH;
						end
						else
						begin
							pc       <= pc + 1'b1;
							eff_addr <= {mem_rdata, adr_lo};
							state    <= cpu_pkg::ST_DATA;
						end
					end
				cpu_pkg::ST_DATA:
					if (mem_write)
						state <= cpu_pkg::ST_WRITE;
					else if (xfer_done)
					begin
						operand     <= mem_rdata;
						exec_strobe <= 1'b1;
						state       <= cpu_pkg::ST_FETCH;
					end
				cpu_pkg::ST_WRITE:
					if (xfer_done)
						state <= cpu_pkg::ST_FETCH;
				cpu_pkg::ST_BRANCH:
				begin
					// full 16-bit add carries across the page
					if (taken)
						pc <= pc + rel_ext;
					state <= cpu_pkg::ST_FETCH;
				end
				default: state <= cpu_pkg::ST_FETCH;
			endcase
		end
	end

endmodule

//--- source/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              reset_routine,
	input  logic              exec_strobe,
	input  cpu_pkg::data_t    operand,
	input  cpu_pkg::alu_op_t  alu_op,
	input  cpu_pkg::reg_sel_t src_sel,
	input  cpu_pkg::reg_sel_t dst_sel,
	input  logic              upd_nz,
	input  logic              upd_c,
	input  logic              upd_v,
	input  logic              set_c,
	input  logic              clr_c,
	output cpu_pkg::data_t    store_data,
	output logic              flag_n,
	output logic              flag_z,
	output logic              flag_c
);

	cpu_pkg::data_t a_reg;
	cpu_pkg::data_t x_reg;
	cpu_pkg::data_t y_reg;
	logic           flag_v;

	cpu_pkg::data_t alu_b;
	cpu_pkg::data_t alu_result;
	logic           alu_neg;
	logic           alu_ov;
	logic           alu_zero;
	logic           alu_carry;

	// source register, shared by stores and implied ops
	always_comb
	begin
		case (src_sel)
			cpu_pkg::SEL_A: store_data = a_reg;
			cpu_pkg::SEL_X: store_data = x_reg;
			cpu_pkg::SEL_Y: store_data = y_reg;
			default:        store_data = operand;
		endcase
	end

	assign alu_b = store_data;

	alu_core i_alu (
		.op        (alu_op),
		.a         (a_reg),
		.b         (alu_b),
		.carry_in  (flag_c),
		.result    (alu_result),
		.neg       (alu_neg),
		.ov        (alu_ov),
		.zero      (alu_zero),
		.carry_out (alu_carry)
	);

	always_ff @(posedge clk)
	begin
		if (reset_routine)
		begin
			a_reg  <= '0;
			x_reg  <= '0;
			y_reg  <= '0;
			flag_n <= 1'b0;
			flag_z <= 1'b0;
			flag_c <= 1'b0;
			flag_v <= 1'b0;
		end
		else if (exec_strobe)
		begin
			case (dst_sel)
				cpu_pkg::SEL_A: a_reg <= alu_result;
				cpu_pkg::SEL_X: x_reg <= alu_result;
				cpu_pkg::SEL_Y: y_reg <= alu_result;
				default:        a_reg <= a_reg;
			endcase
			if (upd_nz)
			begin
				flag_n <= alu_neg;
				flag_z <= alu_zero;
			end
			if (upd_v)
				flag_v <= alu_ov;
			// CLC and SEC win over the ALU carry
			if (set_c)
				flag_c <= 1'b1;
			else if (clr_c)
				flag_c <= 1'b0;
			else if (upd_c)
				flag_c <= alu_carry;
		end
	end

endmodule

//--- source/alu_core.sv
`timescale 1ns/1ps

module alu_core (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::data_t   a,
	input  cpu_pkg::data_t   b,
	input  logic             carry_in,
	output cpu_pkg::data_t   result,
	output logic             neg,
	output logic             ov,
	output logic             zero,
	output logic             carry_out
);

	cpu_pkg::data_t add_b;
	logic           add_cin;
	logic [8:0]     sum;

	// subtract is add of the inverted operand
	always_comb
	begin
		add_b   = b;
		add_cin = carry_in;
		if (op == cpu_pkg::ALU_SUB || op == cpu_pkg::ALU_CMP)
			add_b = ~b;
		if (op == cpu_pkg::ALU_CMP)
			add_cin = 1'b1;
	end

	assign sum = {1'b0, a} + {1'b0, add_b} + {8'd0, add_cin};

	always_comb
	begin
		carry_out = 1'b0;
		ov        = 1'b0;
		case (op)
			cpu_pkg::ALU_ADD, cpu_pkg::ALU_SUB, cpu_pkg::ALU_CMP:
			begin
				result    = sum[7:0];
				carry_out = sum[8];
				ov        = (a[7] == add_b[7]) && (sum[7] != a[7]);
			end
			cpu_pkg::ALU_AND: result = a & b;
			cpu_pkg::ALU_OR:  result = a | b;
			cpu_pkg::ALU_EOR: result = a ^ b;
			cpu_pkg::ALU_INC: result = b + 8'd1;
			cpu_pkg::ALU_DEC: result = b - 8'd1;
			default:          result = b;
		endcase
	end

	assign neg  = result[7];
	assign zero = (result == 8'd0);

endmodule

//--- source/opcode_decoder.sv
`timescale 1ns/1ps

module opcode_decoder (
	input  cpu_pkg::data_t        ir,
	output cpu_pkg::adr_mode_t    mode,
	output cpu_pkg::alu_op_t      alu_op,
	output cpu_pkg::reg_sel_t     src_sel,
	output cpu_pkg::reg_sel_t     dst_sel,
	output logic                  mem_write,
	output logic                  upd_nz,
	output logic                  upd_c,
	output logic                  upd_v,
	output logic                  set_c,
	output logic                  clr_c,
	output cpu_pkg::branch_cond_t branch_cond
);

	cpu_pkg::opcode_t op;

	assign op = cpu_pkg::opcode_t'(ir);

	// addressing mode
	always_comb
	begin
		case (op)
			cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDY_IMM,
			cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_SBC_IMM, cpu_pkg::OP_AND_IMM,
			cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_EOR_IMM, cpu_pkg::OP_CMP_IMM:
				mode = cpu_pkg::MODE_IMM;
			cpu_pkg::OP_LDA_ZPG, cpu_pkg::OP_LDX_ZPG, cpu_pkg::OP_LDY_ZPG,
			cpu_pkg::OP_STA_ZPG, cpu_pkg::OP_STX_ZPG, cpu_pkg::OP_STY_ZPG,
			cpu_pkg::OP_ADC_ZPG, cpu_pkg::OP_SBC_ZPG, cpu_pkg::OP_AND_ZPG,
			cpu_pkg::OP_ORA_ZPG, cpu_pkg::OP_EOR_ZPG, cpu_pkg::OP_CMP_ZPG:
				mode = cpu_pkg::MODE_ZPG;
			cpu_pkg::OP_LDA_ABS, cpu_pkg::OP_LDX_ABS, cpu_pkg::OP_LDY_ABS,
			cpu_pkg::OP_STA_ABS, cpu_pkg::OP_STX_ABS, cpu_pkg::OP_STY_ABS,
			cpu_pkg::OP_ADC_ABS, cpu_pkg::OP_SBC_ABS, cpu_pkg::OP_AND_ABS,
			cpu_pkg::OP_ORA_ABS, cpu_pkg::OP_EOR_ABS, cpu_pkg::OP_CMP_ABS:
				mode = cpu_pkg::MODE_ABS;
			cpu_pkg::OP_INX, cpu_pkg::OP_INY, cpu_pkg::OP_DEX, cpu_pkg::OP_DEY,
			cpu_pkg::OP_TAX, cpu_pkg::OP_TXA, cpu_pkg::OP_TAY, cpu_pkg::OP_TYA,
			cpu_pkg::OP_CLC, cpu_pkg::OP_SEC, cpu_pkg::OP_NOP:
				mode = cpu_pkg::MODE_IMPL;
			cpu_pkg::OP_BCC, cpu_pkg::OP_BCS, cpu_pkg::OP_BEQ,
			cpu_pkg::OP_BNE, cpu_pkg::OP_BMI, cpu_pkg::OP_BPL:
				mode = cpu_pkg::MODE_REL;
			cpu_pkg::OP_JMP_ABS:
				mode = cpu_pkg::MODE_JMP_ABS;
			default:
				mode = cpu_pkg::MODE_INVAL;
		endcase
	end

	// operation, registers and flags
	always_comb
	begin
		alu_op      = cpu_pkg::ALU_PASS;
		src_sel     = cpu_pkg::SEL_NONE;
		dst_sel     = cpu_pkg::SEL_NONE;
		mem_write   = 1'b0;
		upd_nz      = 1'b0;
		upd_c       = 1'b0;
		upd_v       = 1'b0;
		set_c       = 1'b0;
		clr_c       = 1'b0;
		branch_cond = cpu_pkg::BR_CC;
		case (op)
			cpu_pkg::OP_LDA_IMM, cpu_pkg::OP_LDA_ZPG, cpu_pkg::OP_LDA_ABS:
			begin
				dst_sel = cpu_pkg::SEL_A;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_LDX_IMM, cpu_pkg::OP_LDX_ZPG, cpu_pkg::OP_LDX_ABS:
			begin
				dst_sel = cpu_pkg::SEL_X;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_LDY_IMM, cpu_pkg::OP_LDY_ZPG, cpu_pkg::OP_LDY_ABS:
			begin
				dst_sel = cpu_pkg::SEL_Y;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_STA_ZPG, cpu_pkg::OP_STA_ABS:
			begin
				src_sel   = cpu_pkg::SEL_A;
				mem_write = 1'b1;
			end
			cpu_pkg::OP_STX_ZPG, cpu_pkg::OP_STX_ABS:
			begin
				src_sel   = cpu_pkg::SEL_X;
				mem_write = 1'b1;
			end
			cpu_pkg::OP_STY_ZPG, cpu_pkg::OP_STY_ABS:
			begin
				src_sel   = cpu_pkg::SEL_Y;
				mem_write = 1'b1;
			end
			cpu_pkg::OP_ADC_IMM, cpu_pkg::OP_ADC_ZPG, cpu_pkg::OP_ADC_ABS,
			cpu_pkg::OP_SBC_IMM, cpu_pkg::OP_SBC_ZPG, cpu_pkg::OP_SBC_ABS:
			begin
				alu_op  = (op[7:5] == 3'b111) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
				dst_sel = cpu_pkg::SEL_A;
				upd_nz  = 1'b1;
				upd_c   = 1'b1;
				upd_v   = 1'b1;
			end
			cpu_pkg::OP_CMP_IMM, cpu_pkg::OP_CMP_ZPG, cpu_pkg::OP_CMP_ABS:
			begin
				// flags only, A untouched
				alu_op = cpu_pkg::ALU_CMP;
				upd_nz = 1'b1;
				upd_c  = 1'b1;
			end
			cpu_pkg::OP_AND_IMM, cpu_pkg::OP_AND_ZPG, cpu_pkg::OP_AND_ABS,
			cpu_pkg::OP_ORA_IMM, cpu_pkg::OP_ORA_ZPG, cpu_pkg::OP_ORA_ABS,
			cpu_pkg::OP_EOR_IMM, cpu_pkg::OP_EOR_ZPG, cpu_pkg::OP_EOR_ABS:
			begin
				case (op[7:5])
					3'b001:  alu_op = cpu_pkg::ALU_AND;
					3'b000:  alu_op = cpu_pkg::ALU_OR;
					default: alu_op = cpu_pkg::ALU_EOR;
				endcase
				dst_sel = cpu_pkg::SEL_A;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_INX, cpu_pkg::OP_DEX:
			begin
				alu_op  = (op == cpu_pkg::OP_INX) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
				src_sel = cpu_pkg::SEL_X;
				dst_sel = cpu_pkg::SEL_X;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_INY, cpu_pkg::OP_DEY:
			begin
				alu_op  = (op == cpu_pkg::OP_INY) ? cpu_pkg::ALU_INC : cpu_pkg::ALU_DEC;
				src_sel = cpu_pkg::SEL_Y;
				dst_sel = cpu_pkg::SEL_Y;
				upd_nz  = 1'b1;
			end
			// transfers pass the source through
			cpu_pkg::OP_TAX, cpu_pkg::OP_TAY:
			begin
				src_sel = cpu_pkg::SEL_A;
				dst_sel = (op == cpu_pkg::OP_TAX) ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_TXA, cpu_pkg::OP_TYA:
			begin
				src_sel = (op == cpu_pkg::OP_TXA) ? cpu_pkg::SEL_X : cpu_pkg::SEL_Y;
				dst_sel = cpu_pkg::SEL_A;
				upd_nz  = 1'b1;
			end
			cpu_pkg::OP_CLC: clr_c = 1'b1;
			cpu_pkg::OP_SEC: set_c = 1'b1;
			cpu_pkg::OP_BCC: branch_cond = cpu_pkg::BR_CC;
			cpu_pkg::OP_BCS: branch_cond = cpu_pkg::BR_CS;
			cpu_pkg::OP_BEQ: branch_cond = cpu_pkg::BR_EQ;
			cpu_pkg::OP_BNE: branch_cond = cpu_pkg::BR_NE;
			cpu_pkg::OP_BMI: branch_cond = cpu_pkg::BR_MI;
			cpu_pkg::OP_BPL: branch_cond = cpu_pkg::BR_PL;
			default:
			begin
				alu_op = cpu_pkg::ALU_PASS;
			end
		endcase
	end

endmodule

//--- source/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

	typedef logic [`CPU_DATA_W-1:0] data_t;
	typedef logic [`CPU_ADDR_W-1:0] addr_t;

	// standard encodings of the kept instructions
	typedef enum logic [`CPU_DATA_W-1:0] {
		OP_LDA_IMM = 8'hA9, OP_LDA_ZPG = 8'hA5, OP_LDA_ABS = 8'hAD,
		OP_LDX_IMM = 8'hA2, OP_LDX_ZPG = 8'hA6, OP_LDX_ABS = 8'hAE,
		OP_LDY_IMM = 8'hA0, OP_LDY_ZPG = 8'hA4, OP_LDY_ABS = 8'hAC,
		OP_STA_ZPG = 8'h85, OP_STA_ABS = 8'h8D,
		OP_STX_ZPG = 8'h86, OP_STX_ABS = 8'h8E,
		OP_STY_ZPG = 8'h84, OP_STY_ABS = 8'h8C,
		OP_ADC_IMM = 8'h69, OP_ADC_ZPG = 8'h65, OP_ADC_ABS = 8'h6D,
		OP_SBC_IMM = 8'hE9, OP_SBC_ZPG = 8'hE5, OP_SBC_ABS = 8'hED,
		OP_AND_IMM = 8'h29, OP_AND_ZPG = 8'h25, OP_AND_ABS = 8'h2D,
		OP_ORA_IMM = 8'h09, OP_ORA_ZPG = 8'h05, OP_ORA_ABS = 8'h0D,
		OP_EOR_IMM = 8'h49, OP_EOR_ZPG = 8'h45, OP_EOR_ABS = 8'h4D,
		OP_CMP_IMM = 8'hC9, OP_CMP_ZPG = 8'hC5, OP_CMP_ABS = 8'hCD,
		OP_INX = 8'hE8, OP_INY = 8'hC8, OP_DEX = 8'hCA, OP_DEY = 8'h88,
		OP_TAX = 8'hAA, OP_TXA = 8'h8A, OP_TAY = 8'hA8, OP_TYA = 8'h98,
		OP_CLC = 8'h18, OP_SEC = 8'h38, OP_NOP = 8'hEA,
		OP_BCC = 8'h90, OP_BCS = 8'hB0, OP_BEQ = 8'hF0,
		OP_BNE = 8'hD0, OP_BMI = 8'h30, OP_BPL = 8'h10,
		OP_JMP_ABS = 8'h4C
	} opcode_t;

	typedef enum logic [2:0] {
		MODE_IMPL, MODE_IMM, MODE_ZPG, MODE_ABS, MODE_REL, MODE_JMP_ABS, MODE_INVAL
	} adr_mode_t;

	typedef enum logic [3:0] {
		ALU_PASS, ALU_ADD, ALU_SUB, ALU_CMP, ALU_AND, ALU_OR, ALU_EOR, ALU_INC, ALU_DEC
	} alu_op_t;

	typedef enum logic [1:0] {SEL_NONE, SEL_A, SEL_X, SEL_Y} reg_sel_t;

	typedef enum logic [2:0] {BR_CC, BR_CS, BR_EQ, BR_NE, BR_MI, BR_PL} branch_cond_t;

	typedef enum logic [2:0] {
		ST_FETCH, ST_OPER_LO, ST_OPER_HI, ST_DATA, ST_WRITE, ST_BRANCH
	} seq_state_t;

endpackage

//--- include/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data path and bus widths
`define CPU_DATA_W 8
`define CPU_ADDR_W 16

// first opcode fetch after reset, no vector read
`define CPU_RESTART_PC 16'h0200

// high byte for zero-page effective addresses
`define CPU_ZPG_PAGE 8'h00

`endif
